// File: tests/pl_stim.txt
# cmd a b c, hex operands: test n | en mask | pri p w | txrdy b | rxrdy mask | idle n
# push p flit n | inj id flit n | exptx id flit | exprx p flit | waitst s | state s | rdy/act mask | occ/stat p v
test 1
state 0
state 1
rdy 0
en f
waitst 2
rdy f
test 2
push 0 a0000001 3
txrdy 1
exptx 0 a0000001
exptx 0 a0000002
exptx 0 a0000003
stat 0 3
test 3
txrdy 0
pri 0 3
pri 1 1
pri 2 2
pri 3 1
push 0 b0000001 3
push 1 b1000001 3
push 2 b2000001 3
push 3 b3000001 3
txrdy 1
exptx 0 b0000001
exptx 2 b2000001
exptx 0 b0000002
exptx 1 b1000001
exptx 2 b2000002
exptx 3 b3000001
exptx 0 b0000003
exptx 2 b2000003
exptx 3 b3000002
exptx 1 b1000002
exptx 3 b3000003
exptx 1 b1000003
stat 0 6
stat 1 3
test 4
inj 1 c1000001 1
inj 2 c2000001 1
inj 1 c1000002 1
inj 0 c0000001 1
rxrdy 2
exprx 1 c1000001
exprx 1 c1000002
rxrdy 4
exprx 2 c2000001
rxrdy 1
exprx 0 c0000001
rxrdy 0
test 5
inj 3 d3000001 8
waitst 3
rdy 0
rxrdy 8
exprx 3 d3000001
exprx 3 d3000002
exprx 3 d3000003
exprx 3 d3000004
exprx 3 d3000005
rxrdy 0
waitst 2
rdy f
rxrdy 8
exprx 3 d3000006
exprx 3 d3000007
exprx 3 d3000008
rxrdy 0
test 6
txrdy 0
push 1 e1000001 1
en 5
rdy 5
push 0 e0000001 1
push 2 e2000001 2
occ 0 1
occ 1 1
occ 2 2
act 5
txrdy 1
exptx 0 e0000001
exptx 2 e2000001
exptx 2 e2000002
idle 4
occ 1 1
stat 0 7
stat 2 5

// File: list.f
rtl/pl_pkg.sv
rtl/flit_fifo.sv
rtl/wrr_arbiter.sv
rtl/tx_path.sv
rtl/rx_path.sv
rtl/pl_state_ctrl.sv
rtl/ucie_protocol_layer.sv
tests/ucie_protocol_layer_props.sv
tests/tb_ucie_protocol_layer.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ucie_protocol_layer \
    -f list.f --Mdir obj_dir -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    exit 1
fi
if ! grep -qF "*** TEST PASSED ***" sim.log; then
    exit 1
fi
exit 0

// File: tests/tb_ucie_protocol_layer.sv
`timescale 1ns/10ps

module tb_ucie_protocol_layer
    import pl_pkg::*;
();

    logic                     clk;
    logic                     rst_n;
    flit_t                    ul_tx_flit [NUM_PROTOCOLS-1:0];
    logic [NUM_PROTOCOLS-1:0] ul_tx_valid;
    logic [NUM_PROTOCOLS-1:0] ul_tx_ready;
    flit_t                    ul_rx_flit [NUM_PROTOCOLS-1:0];
    logic [NUM_PROTOCOLS-1:0] ul_rx_valid;
    logic [NUM_PROTOCOLS-1:0] ul_rx_ready;
    d2d_flit_t                d2d_tx;
    logic                     d2d_tx_valid;
    logic                     d2d_tx_ready;
    d2d_flit_t                d2d_rx;
    logic                     d2d_rx_valid;
    logic                     d2d_rx_ready;
    logic [NUM_PROTOCOLS-1:0] protocol_enable;
    weight_t                  protocol_priority [NUM_PROTOCOLS-1:0];
    logic [NUM_PROTOCOLS-1:0] protocol_active;
    stat_t                    protocol_stats [NUM_PROTOCOLS-1:0];
    occ_t                     buffer_occupancy [NUM_PROTOCOLS-1:0];
    pl_state_t                layer_state;

    string       lines[$];
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cur_test = -1;
    int          cycles = 0;
    int          cycle_limit = 0;

    ucie_protocol_layer dut_i (.*);

    always #20 clk = ~clk;

    // Run length guard, armed once the command count is known
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if ((cycle_limit > 0) && (cycles >= cycle_limit)) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic next_slot();
        @(posedge clk);
        #2;
    endtask

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_flit(input string what, input flit_t got, input flit_t exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            note_error();
        end
    endtask

    task automatic check_id(input string what, input proto_id_t got, input proto_id_t exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            note_error();
        end
    endtask

    task automatic check_state(input pl_state_t got, input pl_state_t exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: layer_state is %s, expected %s",
                     $time, got.name(), exp.name());
            note_error();
        end
    endtask

    task automatic check_stat(input string what, input stat_t got, input stat_t exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            note_error();
        end
    endtask

    task automatic check_occ(input string what, input occ_t got, input occ_t exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
            note_error();
        end
    endtask

    task automatic check_mask(input string what, input logic [NUM_PROTOCOLS-1:0] got,
                              input logic [NUM_PROTOCOLS-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s is %b, expected %b", $time, what, got, exp);
            note_error();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s is %b, expected %b", $time, what, got, exp);
            note_error();
        end
    endtask

    // Handshake outputs that the layer state alone forces low
    task automatic check_quiet_outputs(input pl_state_t st);
        if ((st == PL_RESET) || (st == PL_INIT)) begin
            check_mask("ul_tx_ready", ul_tx_ready, '0);
            check_mask("ul_rx_valid", ul_rx_valid, '0);
            check_mask("protocol_active", protocol_active, '0);
            check_bit("d2d_tx_valid", d2d_tx_valid, 1'b0);
            check_bit("d2d_rx_ready", d2d_rx_ready, 1'b0);
        end else if (st == PL_FLOW_CONTROL) begin
            check_mask("ul_tx_ready", ul_tx_ready, '0);
            check_bit("d2d_rx_ready", d2d_rx_ready, 1'b0);
        end
    endtask

    task automatic close_test();
        if (cur_test >= 0) begin
            if (test_errors == 0) begin
                $display("test %0d ok", cur_test);
            end else begin
                $display("test %0d failed with %0d errors", cur_test, test_errors);
                tests_failed++;
            end
        end
    endtask

    initial begin
        int          fd;
        string       line;
        string       cmd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        proto_id_t   p;
        clk = 1'b0;
        rst_n = 1'b0;
        ul_tx_valid = '0;
        ul_rx_ready = '0;
        d2d_tx_ready = 1'b0;
        d2d_rx = '0;
        d2d_rx_valid = 1'b0;
        protocol_enable = '0;
        for (int i = 0; i < NUM_PROTOCOLS; i++) begin
            ul_tx_flit[i] = '0;
            protocol_priority[i] = weight_t'(1);
        end
        fd = $fopen("tests/pl_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tests/pl_stim.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                // Skip blank and comment lines
                if ((line.len() > 1) && (line.getc(0) != 8'h23)) begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        cycle_limit = 4 * lines.size() + 200;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        foreach (lines[n]) begin
            c = 32'd1;
            void'($sscanf(lines[n], "%s %h %h %h", cmd, a, b, c));
            p = a[1:0];
            case (cmd)
                "test": begin
                    close_test();
                    cur_test = int'(a);
                    test_errors = 0;
                    tests_run++;
                end
                "en":    protocol_enable = a[NUM_PROTOCOLS-1:0];
                "pri":   protocol_priority[p] = b[WEIGHT_WIDTH-1:0];
                "txrdy": d2d_tx_ready = a[0];
                "rxrdy": ul_rx_ready = a[NUM_PROTOCOLS-1:0];
                "idle":  repeat (int'(a)) next_slot();
                "push": begin
                    for (int k = 0; k < int'(c); k++) begin
                        ul_tx_flit[p] = b + k;
                        ul_tx_valid[p] = 1'b1;
                        @(negedge clk);
                        while (!ul_tx_ready[p]) begin
                            next_slot();
                            @(negedge clk);
                        end
                        next_slot();
                    end
                    ul_tx_valid[p] = 1'b0;
                end
                "inj": begin
                    for (int k = 0; k < int'(c); k++) begin
                        d2d_rx.proto_id = p;
                        d2d_rx.flit = b + k;
                        d2d_rx_valid = 1'b1;
                        @(negedge clk);
                        while (!d2d_rx_ready) begin
                            next_slot();
                            @(negedge clk);
                        end
                        next_slot();
                    end
                    d2d_rx_valid = 1'b0;
                end
                "exptx": begin
                    @(negedge clk);
                    while (!(d2d_tx_valid && d2d_tx_ready)) begin
                        next_slot();
                        @(negedge clk);
                    end
                    check_id("d2d_tx id", d2d_tx.proto_id, p);
                    check_flit("d2d_tx flit", d2d_tx.flit, b);
                    next_slot();
                end
                "exprx": begin
                    @(negedge clk);
                    while (!(ul_rx_valid[p] && ul_rx_ready[p])) begin
                        next_slot();
                        @(negedge clk);
                    end
                    check_flit($sformatf("ul_rx_flit[%0d]", p), ul_rx_flit[p], b);
                    next_slot();
                end
                "waitst": begin
                    @(negedge clk);
                    while (layer_state != pl_state_t'(a[1:0])) begin
                        next_slot();
                        @(negedge clk);
                    end
                    check_quiet_outputs(layer_state);
                    next_slot();
                end
                default: begin
                    @(negedge clk);
                    case (cmd)
                        "state": begin
                            check_state(layer_state, pl_state_t'(a[1:0]));
                            check_quiet_outputs(pl_state_t'(a[1:0]));
                        end
                        "rdy":   check_mask("ul_tx_ready", ul_tx_ready, a[NUM_PROTOCOLS-1:0]);
                        "act":   check_mask("protocol_active", protocol_active,
                                            a[NUM_PROTOCOLS-1:0]);
                        "occ":   check_occ($sformatf("buffer_occupancy[%0d]", p),
                                           buffer_occupancy[p], b[OCC_WIDTH-1:0]);
                        "stat":  check_stat($sformatf("protocol_stats[%0d]", p),
                                            protocol_stats[p], b);
                        default: begin
                            $display("unknown command in stimulus file: %s", cmd);
                            note_error();
                        end
                    endcase
                    next_slot();
                end
            endcase
        end
        close_test();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: tests/ucie_protocol_layer_props.sv
`timescale 1ns/10ps

module ucie_protocol_layer_props
    import pl_pkg::*;
(
    input logic                     clk,
    input logic                     rst_n,
    input d2d_flit_t                d2d_tx,
    input logic                     d2d_tx_valid,
    input logic                     d2d_tx_ready,
    input logic [NUM_PROTOCOLS-1:0] protocol_enable,
    input logic [NUM_PROTOCOLS-1:0] ul_tx_ready,
    input logic                     d2d_rx_ready,
    input occ_t                     buffer_occupancy [NUM_PROTOCOLS-1:0],
    input pl_state_t                layer_state
);

    // Stalled flit stays put unless its protocol was disabled meanwhile
    a_tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (d2d_tx_valid && !d2d_tx_ready) |=> ((d2d_tx == $past(d2d_tx))
            || (protocol_enable != $past(protocol_enable))))
        else $error("d2d_tx changed while the adapter stalled");

    a_no_ready_early: assert property (@(posedge clk)
        ((layer_state == PL_RESET) || (layer_state == PL_INIT))
            |-> ((ul_tx_ready == '0) && !d2d_rx_ready))
        else $error("ready asserted before the layer was active");

    for (genvar i = 0; i < NUM_PROTOCOLS; i++) begin : g_occ
        a_occ_limit: assert property (@(posedge clk)
            buffer_occupancy[i] <= occ_t'(BUFFER_DEPTH))
            else $error("transmit occupancy above queue depth");
    end

endmodule

bind ucie_protocol_layer ucie_protocol_layer_props u_props (.*);

// File: rtl/ucie_protocol_layer.sv
`timescale 1ns/10ps

module ucie_protocol_layer
    import pl_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,

    // Upper layer, one lane per protocol
    input  flit_t                    ul_tx_flit [NUM_PROTOCOLS-1:0],
    input  logic [NUM_PROTOCOLS-1:0] ul_tx_valid,
    output logic [NUM_PROTOCOLS-1:0] ul_tx_ready,
    output flit_t                    ul_rx_flit [NUM_PROTOCOLS-1:0],
    output logic [NUM_PROTOCOLS-1:0] ul_rx_valid,
    input  logic [NUM_PROTOCOLS-1:0] ul_rx_ready,

    // Die-to-die adapter
    output d2d_flit_t                d2d_tx,
    output logic                     d2d_tx_valid,
    input  logic                     d2d_tx_ready,
    input  d2d_flit_t                d2d_rx,
    input  logic                     d2d_rx_valid,
    output logic                     d2d_rx_ready,

    // Configuration and status
    input  logic [NUM_PROTOCOLS-1:0] protocol_enable,
    input  weight_t                  protocol_priority [NUM_PROTOCOLS-1:0],
    output logic [NUM_PROTOCOLS-1:0] protocol_active,
    output stat_t                    protocol_stats [NUM_PROTOCOLS-1:0],
    output occ_t                     buffer_occupancy [NUM_PROTOCOLS-1:0],
    output pl_state_t                layer_state
);

    occ_t rx_count [NUM_PROTOCOLS-1:0];

    pl_state_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .protocol_enable(protocol_enable),
        .tx_count       (buffer_occupancy),
        .rx_count       (rx_count),
        .layer_state    (layer_state),
        .protocol_active(protocol_active)
    );

    // Transmit occupancy doubles as the reported buffer occupancy
    tx_path u_tx (
        .clk              (clk),
        .rst_n            (rst_n),
        .layer_state      (layer_state),
        .protocol_enable  (protocol_enable),
        .protocol_priority(protocol_priority),
        .ul_tx_flit       (ul_tx_flit),
        .ul_tx_valid      (ul_tx_valid),
        .ul_tx_ready      (ul_tx_ready),
        .d2d_tx           (d2d_tx),
        .d2d_tx_valid     (d2d_tx_valid),
        .d2d_tx_ready     (d2d_tx_ready),
        .tx_count         (buffer_occupancy),
        .protocol_stats   (protocol_stats)
    );

    rx_path u_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .layer_state (layer_state),
        .d2d_rx      (d2d_rx),
        .d2d_rx_valid(d2d_rx_valid),
        .d2d_rx_ready(d2d_rx_ready),
        .ul_rx_flit  (ul_rx_flit),
        .ul_rx_valid (ul_rx_valid),
        .ul_rx_ready (ul_rx_ready),
        .rx_count    (rx_count)
    );

endmodule

// File: rtl/pl_state_ctrl.sv
`timescale 1ns/10ps

module pl_state_ctrl
    import pl_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [NUM_PROTOCOLS-1:0] protocol_enable,
    input  occ_t                     tx_count [NUM_PROTOCOLS-1:0],
    input  occ_t                     rx_count [NUM_PROTOCOLS-1:0],
    output pl_state_t                layer_state,
    output logic [NUM_PROTOCOLS-1:0] protocol_active
);

    pl_state_t next_state;
    logic      any_full;
    logic      all_below;

    // Fullness summary over both directions
    always_comb begin
        any_full  = 1'b0;
        all_below = 1'b1;
        for (int i = 0; i < NUM_PROTOCOLS; i++) begin
            if ((tx_count[i] == occ_t'(BUFFER_DEPTH))
                || (rx_count[i] == occ_t'(BUFFER_DEPTH))) begin
                any_full = 1'b1;
            end
            if ((tx_count[i] >= occ_t'(FC_RELEASE_LEVEL))
                || (rx_count[i] >= occ_t'(FC_RELEASE_LEVEL))) begin
                all_below = 1'b0;
            end
        end
    end

    always_comb begin
        next_state = layer_state;
        case (layer_state)
            PL_RESET:        next_state = PL_INIT;
            PL_INIT:         if (|protocol_enable) next_state = PL_ACTIVE;
            PL_ACTIVE:       if (any_full) next_state = PL_FLOW_CONTROL;
            PL_FLOW_CONTROL: if (all_below) next_state = PL_ACTIVE;
            default:         next_state = PL_RESET;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer_state <= PL_RESET;
        end else begin
            layer_state <= next_state;
        end
    end

    for (genvar i = 0; i < NUM_PROTOCOLS; i++) begin : g_active
        assign protocol_active[i] = protocol_enable[i]
                                    && ((tx_count[i] != '0) || (rx_count[i] != '0));
    end

endmodule

// File: rtl/rx_path.sv
`timescale 1ns/10ps

module rx_path
    import pl_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  pl_state_t                layer_state,
    input  d2d_flit_t                d2d_rx,
    input  logic                     d2d_rx_valid,
    output logic                     d2d_rx_ready,
    output flit_t                    ul_rx_flit [NUM_PROTOCOLS-1:0],
    output logic [NUM_PROTOCOLS-1:0] ul_rx_valid,
    input  logic [NUM_PROTOCOLS-1:0] ul_rx_ready,
    output occ_t                     rx_count [NUM_PROTOCOLS-1:0]
);

    logic [NUM_PROTOCOLS-1:0] push;
    logic [NUM_PROTOCOLS-1:0] pop;
    logic [NUM_PROTOCOLS-1:0] not_empty;
    logic                     drain_en;

    // Ready follows whichever queue the presented id points at
    assign d2d_rx_ready = (layer_state == PL_ACTIVE)
                          && (rx_count[d2d_rx.proto_id] != occ_t'(BUFFER_DEPTH));

    assign drain_en = (layer_state == PL_ACTIVE) || (layer_state == PL_FLOW_CONTROL);

    for (genvar i = 0; i < NUM_PROTOCOLS; i++) begin : g_queue
        // Steer by id
        assign push[i] = d2d_rx_valid && d2d_rx_ready
                         && (d2d_rx.proto_id == proto_id_t'(i));
        assign ul_rx_valid[i] = not_empty[i] && drain_en;
        assign pop[i]         = ul_rx_valid[i] && ul_rx_ready[i];

        flit_fifo #(
            .DEPTH(BUFFER_DEPTH)
        ) u_fifo (
            .clk      (clk),
            .rst_n    (rst_n),
            .push     (push[i]),
            .push_flit(d2d_rx.flit),
            .pop      (pop[i]),
            .head_flit(ul_rx_flit[i]),
            .not_empty(not_empty[i]),
            .count    (rx_count[i])
        );
    end

endmodule

// File: rtl/tx_path.sv
`timescale 1ns/10ps

module tx_path
    import pl_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  pl_state_t                layer_state,
    input  logic [NUM_PROTOCOLS-1:0] protocol_enable,
    input  weight_t                  protocol_priority [NUM_PROTOCOLS-1:0],
    input  flit_t                    ul_tx_flit [NUM_PROTOCOLS-1:0],
    input  logic [NUM_PROTOCOLS-1:0] ul_tx_valid,
    output logic [NUM_PROTOCOLS-1:0] ul_tx_ready,
    output d2d_flit_t                d2d_tx,
    output logic                     d2d_tx_valid,
    input  logic                     d2d_tx_ready,
    output occ_t                     tx_count [NUM_PROTOCOLS-1:0],
    output stat_t                    protocol_stats [NUM_PROTOCOLS-1:0]
);

    logic [NUM_PROTOCOLS-1:0] push;
    logic [NUM_PROTOCOLS-1:0] pop;
    logic [NUM_PROTOCOLS-1:0] not_empty;
    logic [NUM_PROTOCOLS-1:0] request;
    flit_t                    head [NUM_PROTOCOLS-1:0];
    logic                     grant_valid;
    proto_id_t                grant_id;
    logic                     tx_accept;
    logic                     drain_en;

    // Adapter side keeps draining during flow-control
    assign drain_en = (layer_state == PL_ACTIVE) || (layer_state == PL_FLOW_CONTROL);

    for (genvar i = 0; i < NUM_PROTOCOLS; i++) begin : g_queue
        assign ul_tx_ready[i] = (layer_state == PL_ACTIVE) && protocol_enable[i]
                                && (tx_count[i] != occ_t'(BUFFER_DEPTH));
        assign push[i]    = ul_tx_valid[i] && ul_tx_ready[i] && protocol_enable[i];
        assign pop[i]     = tx_accept && (grant_id == proto_id_t'(i));
        assign request[i] = protocol_enable[i] && not_empty[i];

        flit_fifo #(
            .DEPTH(BUFFER_DEPTH)
        ) u_fifo (
            .clk      (clk),
            .rst_n    (rst_n),
            .push     (push[i]),
            .push_flit(ul_tx_flit[i]),
            .pop      (pop[i]),
            .head_flit(head[i]),
            .not_empty(not_empty[i]),
            .count    (tx_count[i])
        );
    end

    wrr_arbiter u_arb (
        .clk            (clk),
        .rst_n          (rst_n),
        .request        (request),
        .priority_weight(protocol_priority),
        .advance        (tx_accept),
        .grant_valid    (grant_valid),
        .grant_id       (grant_id)
    );

    assign d2d_tx_valid = grant_valid && drain_en;
    assign d2d_tx       = '{proto_id: grant_id, flit: head[grant_id]};
    assign tx_accept    = d2d_tx_valid && d2d_tx_ready;

    // Saturating per-protocol transmit counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PROTOCOLS; i++) begin
                protocol_stats[i] <= '0;
            end
        end else if (tx_accept && (protocol_stats[grant_id] != '1)) begin
            protocol_stats[grant_id] <= protocol_stats[grant_id] + stat_t'(1);
        end
    end

endmodule

// File: rtl/wrr_arbiter.sv
`timescale 1ns/10ps

module wrr_arbiter
    import pl_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [NUM_PROTOCOLS-1:0] request,
    input  weight_t                  priority_weight [NUM_PROTOCOLS-1:0],
    input  logic                     advance,
    output logic                     grant_valid,
    output proto_id_t                grant_id
);

    weight_t   weight_cnt [NUM_PROTOCOLS-1:0];
    proto_id_t last_served;
    logic      hold_valid;
    proto_id_t hold_id;
    logic      held;
    logic      pick_valid;
    proto_id_t pick_id;
    logic      after_zero;
    logic      reload;

    // Largest nonzero weight wins, scan starts after last_served so ties rotate
    always_comb begin
        weight_t   best_w;
        proto_id_t idx;
        best_w     = '0;
        idx        = '0;
        pick_valid = 1'b0;
        pick_id    = last_served;
        for (int k = 1; k <= NUM_PROTOCOLS; k++) begin
            idx = proto_id_t'((int'(last_served) + k) % NUM_PROTOCOLS);
            if (request[idx] && (weight_cnt[idx] > best_w)) begin
                best_w     = weight_cnt[idx];
                pick_id    = idx;
                pick_valid = 1'b1;
            end
        end
    end

    // A stalled grant stays put until the adapter takes it
    assign held        = hold_valid && request[hold_id];
    assign grant_valid = held || pick_valid;
    assign grant_id    = held ? hold_id : pick_id;

    // Would the counters all be zero once this transfer is charged
    always_comb begin
        after_zero = 1'b1;
        for (int i = 0; i < NUM_PROTOCOLS; i++) begin
            if (advance && (grant_id == proto_id_t'(i))) begin
                if (weight_cnt[i] > weight_t'(1)) begin
                    after_zero = 1'b0;
                end
            end else if (weight_cnt[i] != '0) begin
                after_zero = 1'b0;
            end
        end
    end

    assign reload = advance ? after_zero : ((|request) && !grant_valid);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PROTOCOLS; i++) begin
                weight_cnt[i] <= priority_weight[i];
            end
            last_served <= proto_id_t'(NUM_PROTOCOLS - 1);
            hold_valid  <= 1'b0;
            hold_id     <= '0;
        end else begin
            if (reload) begin
                for (int i = 0; i < NUM_PROTOCOLS; i++) begin
                    weight_cnt[i] <= priority_weight[i];
                end
            end else if (advance) begin
                weight_cnt[grant_id] <= weight_cnt[grant_id] - weight_t'(1);
            end
            if (advance) begin
                last_served <= grant_id;
            end
            hold_valid <= grant_valid && !advance;
            hold_id    <= grant_id;
        end
    end

endmodule

// File: rtl/flit_fifo.sv
`timescale 1ns/10ps

module flit_fifo
    import pl_pkg::*;
#(
    parameter int DEPTH = BUFFER_DEPTH
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push,
    input  flit_t push_flit,
    input  logic  pop,
    output flit_t head_flit,
    output logic  not_empty,
    output occ_t  count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [PTR_W-1:0] ptr_t;

    flit_t mem [DEPTH];
    ptr_t  wr_ptr;
    ptr_t  rd_ptr;

    // Wrap at DEPTH so non power of two depths work too
    function automatic ptr_t next_ptr(ptr_t p);
        if (p == ptr_t'(DEPTH - 1)) begin
            return '0;
        end
        return p + ptr_t'(1);
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_flit;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + occ_t'(1);
                2'b01:   count <= count - occ_t'(1);
                default: count <= count;
            endcase
        end
    end

    // Head is visible the cycle after it was written
    assign head_flit = mem[rd_ptr];
    assign not_empty = (count != '0);

endmodule

// File: rtl/pl_pkg.sv
package pl_pkg;

    // Link geometry
    localparam int NUM_PROTOCOLS = 4;
    localparam int FLIT_WIDTH = 32;
    localparam int BUFFER_DEPTH = 8;

    // Every queue must drop below this level before flow-control is released
    localparam int FC_RELEASE_LEVEL = BUFFER_DEPTH - 4;

    localparam int WEIGHT_WIDTH = 8;
    localparam int STAT_WIDTH = 32;

    // Derived widths
    localparam int PROTO_ID_WIDTH = $clog2(NUM_PROTOCOLS);
    localparam int OCC_WIDTH = $clog2(BUFFER_DEPTH + 1);

    typedef logic [FLIT_WIDTH-1:0] flit_t;
    typedef logic [PROTO_ID_WIDTH-1:0] proto_id_t;
    typedef logic [OCC_WIDTH-1:0] occ_t;
    typedef logic [WEIGHT_WIDTH-1:0] weight_t;
    typedef logic [STAT_WIDTH-1:0] stat_t;

    // Layer controller states
    typedef enum logic [1:0] {
        PL_RESET        = 2'd0,
        PL_INIT         = 2'd1,
        PL_ACTIVE       = 2'd2,
        PL_FLOW_CONTROL = 2'd3
    } pl_state_t;

    // Flit as exchanged with the die-to-die adapter, both directions
    typedef struct packed {
        proto_id_t proto_id;
        flit_t     flit;
    } d2d_flit_t;

endpackage
